//--- source/ipv4_pkg.sv
package ipv4_pkg;

  ////////////////////////////////////////
  // Basic types and protocol constants
  ////////////////////////////////////////
  typedef logic [31:0] ipv4_addr_t;
  typedef logic [47:0] mac_addr_t;

  localparam int          ipv4_hdr_len   = 20;       // Header bytes, no options
  localparam logic [15:0] ethertype_ipv4 = 16'h0800;
  localparam ipv4_addr_t  ipv4_broadcast = '1;
  localparam mac_addr_t   mac_broadcast  = '1;
  localparam logic [7:0]  ipv4_ttl       = 8'd64;
  localparam logic [3:0]  ipv4_ver       = 4'd4;
  localparam logic [3:0]  ipv4_ihl       = 4'd5;     // Length in 32-bit words

  ////////////////////////////////////////
  // Header record, first wire byte at MSB
  ////////////////////////////////////////
  typedef struct packed {
    logic [3:0]  ver;
    logic [3:0]  ihl;
    logic [7:0]  qos;
    logic [15:0] length;  // Header plus payload
    logic [15:0] id;
    logic        zero;    // Reserved flag bit
    logic        df;
    logic        mf;
    logic [12:0] fo;
    logic [7:0]  ttl;
    logic [7:0]  proto;
    logic [15:0] chksum;
    ipv4_addr_t  src_ip;
    ipv4_addr_t  dst_ip;
  } ipv4_hdr_t;

  // Byte from the MAC receiver, MAC header already stripped
  typedef struct packed {
    logic [7:0]  dat;
    logic        val;
    logic        sof;
    logic        eof;
    logic        err;
    logic [15:0] ethertype; // Valid with sof
  } eth_rx_t;

  // Byte towards the MAC transmitter
  typedef struct packed {
    logic [7:0]  dat;
    logic        val;
    logic        sof;
    logic        eof;
    mac_addr_t   dst_mac;
    mac_addr_t   src_mac;
    logic [15:0] ethertype;
  } eth_tx_t;

  // Forwarded payload byte with its header
  typedef struct packed {
    logic [7:0] dat;
    logic       val;
    logic       sof;
    logic       eof;
    ipv4_hdr_t  hdr;
  } ipv4_rx_t;

  typedef struct packed {
    ipv4_addr_t  dst_ip;
    logic [7:0]  proto;
    logic [15:0] payload_len;
    logic        broadcast;   // Skip ARP, send to all stations
  } ipv4_tx_req_t;

endpackage

//--- source/ipv4_chksum_acc.sv
`timescale 1ns/10ps

module ipv4_chksum_acc (
  input  logic        clk,
  input  logic        fsm_rst,
  input  logic        clear,
  input  logic        in_val,
  input  logic [15:0] in_dat,
  output logic [15:0] sum
);

  logic [15:0] base;
  logic [16:0] add;
  logic [15:0] folded;

  // A word arriving with clear starts the new sum
  assign base = clear ? 16'h0000 : sum;
  assign add  = {1'b0, base} + {1'b0, in_dat};

  // End-around carry, a single fold is enough
  assign folded = add[15:0] + {15'd0, add[16]};

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      sum <= '0;
    end else if (in_val) begin
      sum <= folded;
    end else begin
      sum <= base;
    end
  end

endmodule

//--- source/ipv4_rx_parser.sv
`timescale 1ns/10ps

module ipv4_rx_parser (
  input  logic                 clk,
  input  logic                 fsm_rst,
  input  ipv4_pkg::eth_rx_t    eth_rx,
  input  ipv4_pkg::ipv4_addr_t dev_ip,
  output ipv4_pkg::ipv4_rx_t   ipv4_rx,
  output logic                 chksum_err
);

  import ipv4_pkg::*;

  typedef enum logic [1:0] {
    rx_idle,
    rx_hdr,
    rx_pay
  } rx_state_t;

  rx_state_t   state;
  logic [15:0] cnt;       // Bytes taken so far
  logic [15:0] byte_num;  // Number of the byte on the input now
  ipv4_hdr_t   hdr;
  logic        hdr_end;   // First cycle with a full header
  logic [15:0] sum;
  logic        frame_start;
  logic        word_val;
  logic        addr_ok;
  logic        fwd_ok;
  logic [7:0]  out_dat;
  logic        out_val;
  logic        out_sof;
  logic        out_eof;

  assign byte_num = cnt + 16'd1;

  // Only plain headers are taken, so the first byte must be 0x45
  assign frame_start = eth_rx.val && eth_rx.sof && !eth_rx.eof && !eth_rx.err &&
                       (eth_rx.ethertype == ethertype_ipv4) &&
                       (eth_rx.dat == {ipv4_ver, ipv4_ihl});

  // Even bytes close a 16-bit word with the byte before
  assign word_val = eth_rx.val && (state == rx_hdr) && !frame_start && !byte_num[0];

  ipv4_chksum_acc i_chksum_acc (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .clear   (frame_start),
    .in_val  (word_val),
    .in_dat  ({hdr[7:0], eth_rx.dat}),
    .sum     (sum)
  );

  ////////////////////////////////////////
  // Verdict that holds once the header is in
  ////////////////////////////////////////
  assign addr_ok = (hdr.dst_ip == dev_ip) || (hdr.dst_ip == ipv4_broadcast);
  assign fwd_ok  = (sum == 16'hffff) && addr_ok && (hdr.length > 16'(ipv4_hdr_len));

  assign chksum_err = hdr_end && (sum != 16'hffff);

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state   <= rx_idle;
      cnt     <= '0;
      hdr_end <= 1'b0;
      out_val <= 1'b0;
      out_sof <= 1'b0;
      out_eof <= 1'b0;
    end else begin
      hdr_end <= 1'b0;
      out_val <= 1'b0;
      out_sof <= 1'b0;
      out_eof <= 1'b0;
      if (frame_start) begin
        state <= rx_hdr;
        cnt   <= 16'd1;
      end else begin
        if (eth_rx.val) begin
          case (state)
            rx_hdr: begin
              cnt <= byte_num;
              if (byte_num == 16'(ipv4_hdr_len)) begin
                hdr_end <= 1'b1;
                state   <= rx_pay;
              end
            end
            rx_pay: begin
              cnt     <= byte_num;
              out_val <= fwd_ok && !eth_rx.err;
              out_sof <= fwd_ok && !eth_rx.err && (byte_num == 16'(ipv4_hdr_len + 1));
              out_eof <= fwd_ok && !eth_rx.err && (byte_num == hdr.length);
              if (byte_num == hdr.length) state <= rx_idle; // Ethernet padding follows
            end
            default: ;
          endcase
        end
        if (eth_rx.eof || eth_rx.err) state <= rx_idle;
      end
    end
  end

  // Header shift, newest byte at the LSB end
  always_ff @(posedge clk) begin
    if (eth_rx.val && (frame_start || state == rx_hdr)) begin
      hdr <= {hdr[151:0], eth_rx.dat};
    end
    out_dat <= eth_rx.dat;
  end

  assign ipv4_rx = '{
    dat: out_dat,
    val: out_val,
    sof: out_sof,
    eof: out_eof,
    hdr: hdr
  };

  // Forwarded bytes only follow a plain header that sits aligned in the shift register
  a_val_plain_hdr: assert property (@(posedge clk) disable iff (fsm_rst)
    ipv4_rx.val |-> (ipv4_rx.hdr.ver == ipv4_ver) && (ipv4_rx.hdr.ihl == ipv4_ihl));

endmodule

//--- source/ipv4_tx_framer.sv
`timescale 1ns/10ps

module ipv4_tx_framer (
  input  logic                   clk,
  input  logic                   fsm_rst,
  input  ipv4_pkg::ipv4_tx_req_t tx_req,
  input  logic                   tx_start,
  input  ipv4_pkg::ipv4_addr_t   dev_ip,
  input  ipv4_pkg::mac_addr_t    dev_mac,
  output logic                   tx_busy,
  output logic                   tx_abort,
  output logic                   arp_req,
  output ipv4_pkg::ipv4_addr_t   arp_ip,
  input  logic                   arp_val,
  input  logic                   arp_err,
  input  ipv4_pkg::mac_addr_t    arp_mac,
  output logic                   pay_rd,
  input  logic [7:0]             pay_dat,
  output ipv4_pkg::eth_tx_t      eth_tx
);

  import ipv4_pkg::*;

  typedef enum logic [2:0] {
    tx_idle,
    tx_sum,   // Ten header words into the accumulator
    tx_fin,   // Checksum into the header
    tx_arp,
    tx_hdr,
    tx_pay
  } tx_state_t;

  tx_state_t        state;
  logic [3:0]       widx;
  logic [4:0]       hcnt;
  logic [15:0]      pcnt;
  logic [15:0]      id_cnt;
  ipv4_hdr_t        hdr;
  logic [9:0][15:0] hdr_w;
  logic [19:0][7:0] hdr_b;
  logic             bcast;
  logic [15:0]      pay_len;
  mac_addr_t        dst_mac;
  logic [15:0]      sum;
  logic             start_ok;
  logic             hdr_last;
  logic             pay_last;

  assign start_ok = (state == tx_idle) && tx_start;  // Strobes while busy are dropped
  assign hdr_w    = hdr;
  assign hdr_b    = hdr;
  assign hdr_last = (state == tx_hdr) && (hcnt == 5'(ipv4_hdr_len - 1));
  assign pay_last = (state == tx_pay) && (pcnt == pay_len - 16'd1);

  ipv4_chksum_acc i_chksum_acc (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .clear   (start_ok),
    .in_val  (state == tx_sum),
    .in_dat  (hdr_w[4'(ipv4_hdr_len / 2 - 1) - widx]),
    .sum     (sum)
  );

  ////////////////////////////////////////
  // Frame FSM
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state  <= tx_idle;
      widx   <= '0;
      hcnt   <= '0;
      pcnt   <= '0;
      id_cnt <= '0;
    end else begin
      case (state)
        tx_idle: begin
          widx <= '0;
          if (tx_start) state <= tx_sum;
        end
        tx_sum: begin
          widx <= widx + 4'd1;
          if (widx == 4'(ipv4_hdr_len / 2 - 1)) state <= tx_fin;
        end
        tx_fin: begin
          hcnt  <= '0;
          state <= bcast ? tx_hdr : tx_arp;
        end
        tx_arp: begin
          if (arp_err) begin
            state <= tx_idle;  // Frame dropped
          end else if (arp_val) begin
            state <= tx_hdr;
          end
        end
        tx_hdr: begin
          hcnt <= hcnt + 5'd1;
          pcnt <= '0;
          if (hdr_last) state <= (pay_len == 16'd0) ? tx_idle : tx_pay;
        end
        tx_pay: begin
          pcnt <= pcnt + 16'd1;
          if (pay_last) state <= tx_idle;
        end
        default: state <= tx_idle;
      endcase
      if (eth_tx.eof) id_cnt <= id_cnt + 16'd1;  // Only frames really sent
    end
  end

  // Header record and lookup result
  always_ff @(posedge clk) begin
    if (start_ok) begin
      hdr <= '{
        ver:    ipv4_ver,
        ihl:    ipv4_ihl,
        qos:    8'd0,
        length: tx_req.payload_len + 16'(ipv4_hdr_len),
        id:     id_cnt,
        zero:   1'b0,
        df:     1'b1,
        mf:     1'b0,
        fo:     13'd0,
        ttl:    ipv4_ttl,
        proto:  tx_req.proto,
        chksum: 16'd0,
        src_ip: dev_ip,
        dst_ip: tx_req.dst_ip
      };
      bcast   <= tx_req.broadcast;
      pay_len <= tx_req.payload_len;
    end
    if (state == tx_fin) begin
      hdr.chksum <= ~sum;
      if (bcast) dst_mac <= mac_broadcast;
    end
    if (state == tx_arp && arp_val) dst_mac <= arp_mac;
  end

  assign tx_busy  = (state != tx_idle);
  assign tx_abort = (state == tx_arp) && arp_err;
  assign arp_req  = (state == tx_fin) && !bcast;
  assign arp_ip   = hdr.dst_ip;

  // One read ahead of each payload byte
  assign pay_rd = (hdr_last && pay_len != 16'd0) || ((state == tx_pay) && !pay_last);

  ////////////////////////////////////////
  // Output byte stream
  ////////////////////////////////////////
  always_comb begin
    if (state == tx_pay) begin
      eth_tx.dat = pay_dat;  // Straight from the client
    end else begin
      eth_tx.dat = hdr_b[5'(ipv4_hdr_len - 1) - hcnt];
    end
    eth_tx.val       = (state == tx_hdr) || (state == tx_pay);
    eth_tx.sof       = (state == tx_hdr) && (hcnt == 5'd0);
    eth_tx.eof       = pay_last || (hdr_last && pay_len == 16'd0);
    eth_tx.dst_mac   = dst_mac;
    eth_tx.src_mac   = dev_mac;
    eth_tx.ethertype = ethertype_ipv4;
  end

  // Frame bytes are contiguous and never restart mid frame
  a_sof_in_frame: assert property (@(posedge clk) disable iff (fsm_rst)
    eth_tx.val && !eth_tx.eof |=> eth_tx.val && !eth_tx.sof);

  // Each read is served while busy and answered by a byte next cycle
  a_pay_rd_busy: assert property (@(posedge clk) disable iff (fsm_rst)
    pay_rd |-> tx_busy ##1 (eth_tx.val && !eth_tx.sof));

endmodule

//--- source/ipv4_core.sv
`timescale 1ns/10ps

module ipv4_core (
  input  logic                   clk,
  input  logic                   fsm_rst,
  // Receive side
  input  ipv4_pkg::eth_rx_t      eth_rx,
  output ipv4_pkg::ipv4_rx_t     ipv4_rx,
  output logic                   chksum_err,
  // Transmit side
  output ipv4_pkg::eth_tx_t      eth_tx,
  input  ipv4_pkg::ipv4_tx_req_t tx_req,
  input  logic                   tx_start,
  output logic                   tx_busy,
  output logic                   tx_abort,
  output logic                   pay_rd,
  input  logic [7:0]             pay_dat,
  // ARP table
  output logic                   arp_req,
  output ipv4_pkg::ipv4_addr_t   arp_ip,
  input  logic                   arp_val,
  input  logic                   arp_err,
  input  ipv4_pkg::mac_addr_t    arp_mac,
  // Static device identity
  input  ipv4_pkg::ipv4_addr_t   dev_ip,
  input  ipv4_pkg::mac_addr_t    dev_mac
);

  ipv4_rx_parser i_rx_parser (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .eth_rx     (eth_rx),
    .dev_ip     (dev_ip),
    .ipv4_rx    (ipv4_rx),
    .chksum_err (chksum_err)
  );

  ipv4_tx_framer i_tx_framer (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .tx_req   (tx_req),
    .tx_start (tx_start),
    .dev_ip   (dev_ip),
    .dev_mac  (dev_mac),
    .tx_busy  (tx_busy),
    .tx_abort (tx_abort),
    .arp_req  (arp_req),
    .arp_ip   (arp_ip),
    .arp_val  (arp_val),
    .arp_err  (arp_err),
    .arp_mac  (arp_mac),
    .pay_rd   (pay_rd),
    .pay_dat  (pay_dat),
    .eth_tx   (eth_tx)
  );

endmodule

//--- sim/ipv4_core_tb.sv
`timescale 1ns/10ps

module ipv4_core_tb;

  import ipv4_pkg::*;

  localparam int max_pay       = 24;
  localparam int longest_frame = ipv4_hdr_len + max_pay;
  localparam int cycle_limit   = 20 * (longest_frame + 40);

  logic         clk;
  logic         fsm_rst;
  eth_rx_t      eth_rx;
  ipv4_rx_t     ipv4_rx;
  logic         chksum_err;
  eth_tx_t      eth_tx;
  ipv4_tx_req_t tx_req;
  logic         tx_start;
  logic         tx_busy;
  logic         tx_abort;
  logic         pay_rd;
  logic [7:0]   pay_dat;
  logic         arp_req;
  ipv4_addr_t   arp_ip;
  logic         arp_val;
  logic         arp_err;
  mac_addr_t    arp_mac;
  ipv4_addr_t   dev_ip;
  mac_addr_t    dev_mac;

  logic [31:0]  rng = 32'h258f7705;
  int           errors;
  int           checks;
  int           cycles;
  int           arp_seen;
  int           abort_seen;
  int           cerr_seen;
  int           rx_idx;
  int           tx_idx;
  logic [159:0] rx_hdr_exp;
  logic [7:0]   rx_exp[$];   // Payload bytes still due on ipv4_rx
  logic [7:0]   tx_exp[$];   // Frame bytes still due on eth_tx
  logic [7:0]   pay_src[$];  // Bytes the client hands out on pay_rd
  mac_addr_t    tx_mac;
  logic [15:0]  tx_id;

  ipv4_core i_ipv4_core (.*);

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////
  function logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // Ones'-complement sum of the ten header words
  function automatic logic [15:0] ones_sum(input logic [159:0] h);
    logic [16:0] s;
    s = '0;
    for (int i = 0; i < 10; i++) begin
      s = {1'b0, s[15:0]} + {1'b0, h[159 - 16*i -: 16]};
      s = {1'b0, s[15:0]} + {16'd0, s[16]};  // End-around carry
    end
    return s[15:0];
  endfunction

  function automatic logic [159:0] make_hdr(input logic [15:0] len, input logic [15:0] id,
                                            input logic [7:0] proto, input logic [31:0] src,
                                            input logic [31:0] dst);
    logic [159:0] h;
    h = {ipv4_ver, ipv4_ihl, 8'h00, len, id, 16'h4000, ipv4_ttl, proto, 16'h0000, src, dst};
    h[79:64] = ~ones_sum(h);
    return h;
  endfunction

  task automatic compare(input string name, input logic [159:0] exp, input logic [159:0] got);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAIL %0t %s expected %0h got %0h", $time, name, exp, got);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  ////////////////////////////////////////
  // Clock, run limit and client model
  ////////////////////////////////////////
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
      $display("test failed");
      $finish;
    end
  end

  always @(posedge clk) begin
    if (pay_rd) begin
      #2;
      pay_dat = pay_src.pop_front();  // Byte due one cycle after the read
    end
  end

  // Scoreboards for both byte streams
  always @(posedge clk) begin
    if (!fsm_rst) begin
      if (arp_req) arp_seen++;
      if (tx_abort) abort_seen++;
      if (chksum_err) cerr_seen++;
      if (ipv4_rx.val) begin
        assert (rx_exp.size() != 0) else begin
          errors++;
          $display("ipv4_rx.val high at %0t while no payload byte is due", $time);
        end
        if (rx_exp.size() != 0) begin
          if (rx_idx == 0) compare("ipv4_rx.hdr", rx_hdr_exp, 160'(ipv4_rx.hdr));
          compare("ipv4_rx.dat", 160'(rx_exp[0]), 160'(ipv4_rx.dat));
          compare("ipv4_rx.sof", 160'(rx_idx == 0), 160'(ipv4_rx.sof));
          compare("ipv4_rx.eof", 160'(rx_exp.size() == 1), 160'(ipv4_rx.eof));
          void'(rx_exp.pop_front());
          rx_idx++;
        end
      end
      if (eth_tx.val) begin
        assert (tx_exp.size() != 0) else begin
          errors++;
          $display("eth_tx.val high at %0t while no frame byte is due", $time);
        end
        if (tx_exp.size() != 0) begin
          compare("eth_tx.dat", 160'(tx_exp[0]), 160'(eth_tx.dat));
          compare("eth_tx.sof", 160'(tx_idx == 0), 160'(eth_tx.sof));
          compare("eth_tx.eof", 160'(tx_exp.size() == 1), 160'(eth_tx.eof));
          compare("eth_tx.dst_mac", 160'(tx_mac), 160'(eth_tx.dst_mac));
          compare("eth_tx.src_mac", 160'(dev_mac), 160'(eth_tx.src_mac));
          compare("eth_tx.ethertype", 160'(ethertype_ipv4), 160'(eth_tx.ethertype));
          void'(tx_exp.pop_front());
          tx_idx++;
        end
      end
    end
  end

  // Busy rises after an accepted start and falls after the last frame byte
  a_busy_start: assert property (@(posedge clk) disable iff (fsm_rst)
    tx_start && !tx_busy |=> tx_busy)
    else begin
      errors++;
      $display("tx_busy did not rise at %0t after an accepted tx_start", $time);
    end

  a_busy_eof: assert property (@(posedge clk) disable iff (fsm_rst)
    eth_tx.val && eth_tx.eof |=> !tx_busy)
    else begin
      errors++;
      $display("tx_busy still high at %0t in the cycle after eth_tx.eof", $time);
    end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////
  task automatic send_rx(input logic [31:0] dst, input int len, input logic corrupt);
    logic [159:0] h;
    logic [7:0]   b;
    logic         fwd;
    int           n_err;
    n_err = cerr_seen;
    h = make_hdr(16'(len + ipv4_hdr_len), 16'(next_rand()), 8'd17, next_rand(), dst);
    if (corrupt) h[120] = ~h[120];  // Flipped id bit breaks the checksum
    fwd = !corrupt && (dst == dev_ip || dst == ipv4_broadcast);
    rx_hdr_exp = h;
    rx_idx = 0;
    for (int i = 0; i < len + ipv4_hdr_len; i++) begin
      if (i < ipv4_hdr_len) b = h[159 - 8*i -: 8];
      else b = 8'(next_rand());
      if (fwd && i >= ipv4_hdr_len) rx_exp.push_back(b);
      next_cycle();
      eth_rx = '{dat: b, val: 1'b1, sof: (i == 0), eof: (i == len + ipv4_hdr_len - 1),
                 err: 1'b0, ethertype: ethertype_ipv4};
    end
    next_cycle();
    eth_rx = '0;
    repeat (4) next_cycle();
    compare("rx payload bytes missing", 160'(0), 160'(rx_exp.size()));
    compare("chksum_err pulses", 160'(corrupt), 160'(cerr_seen - n_err));
  endtask

  task automatic send_tx(input logic bcast, input logic fail_arp, input int len);
    logic [159:0] h;
    logic [31:0]  dst;
    logic [7:0]   proto;
    logic [7:0]   b;
    int           n_arp;
    int           n_abort;
    dst = bcast ? ipv4_broadcast : next_rand();
    proto = 8'(next_rand());
    tx_mac = bcast ? mac_broadcast : {16'(next_rand()), next_rand()};
    n_arp = arp_seen;
    n_abort = abort_seen;
    h = make_hdr(16'(len + ipv4_hdr_len), tx_id, proto, dev_ip, dst);
    tx_idx = 0;
    if (!fail_arp) begin
      for (int i = 0; i < ipv4_hdr_len; i++) tx_exp.push_back(h[159 - 8*i -: 8]);
      for (int i = 0; i < len; i++) begin
        b = 8'(next_rand());
        pay_src.push_back(b);
        tx_exp.push_back(b);
      end
    end
    next_cycle();
    tx_req = '{dst_ip: dst, proto: proto, payload_len: 16'(len), broadcast: bcast};
    tx_start = 1'b1;
    next_cycle();
    tx_start = 1'b0;
    if (!bcast) begin
      while (!arp_req) next_cycle();
      compare("arp_ip", 160'(dst), 160'(arp_ip));
      repeat (3) next_cycle();  // Table lookup latency
      arp_val = !fail_arp;
      arp_err = fail_arp;
      arp_mac = tx_mac;
      next_cycle();
      arp_val = 1'b0;
      arp_err = 1'b0;
    end
    while (tx_busy) next_cycle();
    repeat (2) next_cycle();
    compare("arp_req pulses", 160'(!bcast), 160'(arp_seen - n_arp));
    compare("tx_abort pulses", 160'(fail_arp), 160'(abort_seen - n_abort));
    compare("tx frame bytes missing", 160'(0), 160'(tx_exp.size()));
    if (!fail_arp) tx_id++;
  endtask

  initial begin
    fsm_rst  = 1'b1;
    eth_rx   = '0;
    tx_req   = '0;
    tx_start = 1'b0;
    pay_dat  = 8'd0;
    arp_val  = 1'b0;
    arp_err  = 1'b0;
    arp_mac  = '0;
    tx_id    = 16'd0;
    dev_ip   = next_rand();
    dev_mac  = {16'(next_rand()), next_rand()};
    repeat (8) @(posedge clk);
    #2 fsm_rst = 1'b0;
    compare("outputs after reset", 160'(0),
            160'({eth_tx.val, ipv4_rx.val, tx_busy, arp_req, pay_rd, tx_abort, chksum_err}));

    send_rx(dev_ip, 16, 1'b0);
    send_rx(dev_ip ^ 32'h0000_0100, 9, 1'b0);  // Foreign address is dropped
    send_rx(ipv4_broadcast, 5, 1'b0);
    send_rx(dev_ip, 12, 1'b1);
    send_tx(1'b0, 1'b0, 12);
    send_tx(1'b1, 1'b0, 7);
    send_tx(1'b0, 1'b1, 10);
    send_tx(1'b0, 1'b0, max_pay);

    repeat (4) @(posedge clk);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- src.f
source/ipv4_pkg.sv
source/ipv4_chksum_acc.sv
source/ipv4_rx_parser.sv
source/ipv4_tx_framer.sv
source/ipv4_core.sv
sim/ipv4_core_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the IPv4 core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f src.f --top-module ipv4_core_tb -o ipv4_core_sim

# A DUT assertion may stop the run early, the log decides the result
./obj_dir/ipv4_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "test passed" sim.log; then
  exit 0
fi
echo "Simulation did not report success"
exit 1
